// File: sys_info_consts.svh
`ifndef SYS_INFO_CONSTS_SVH
`define SYS_INFO_CONSTS_SVH

// **************************************************
// Sample-rate measurement
// **************************************************
`define SYS_INFO_WINDOW       1000  // Clocks per window, short for sim
`define SYS_INFO_RATE_DIGITS  2     // BCD digits of the sample count
`define SYS_INFO_FRAME_DIGITS 4     // BCD digits of the frame count

`define SYS_INFO_BANKS        4     // SDRAM banks observed

// Status address fields
`define SYS_INFO_RGN_MSB      7     // Region select, upper bit
`define SYS_INFO_RGN_LSB      6     // Region select, lower bit
`define SYS_INFO_REG_STATS    2'd0  // Per-bank ready totals
`define SYS_INFO_REG_FRAME    2'd1  // Frame counter bytes
`define SYS_INFO_REG_RATE     2'd2  // Latched sample rate
`define SYS_INFO_REG_CFG      2'd3  // Core settings snapshot

`endif

// File: sys_info_pkg.sv
package sys_info_pkg;

    `include "sys_info_consts.svh"

    // **************************************************
    // Status bus types
    // **************************************************
    typedef logic [7:0] status_addr_t;  // Region in 7:6, byte select below
    typedef logic [7:0] status_byte_t;  // One byte returned to the host

    // Frame counter, four packed BCD digits
    typedef logic [4*`SYS_INFO_FRAME_DIGITS-1:0] bcd16_t;

    typedef logic [`SYS_INFO_BANKS-1:0] bank_rdy_t;  // One ready per bank

    // Read front end states
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // Waiting for a host request
        WAIT_DATA = 2'd1,  // Address out, status byte registering
        RESP      = 2'd2   // Byte captured, offered to the host
    } port_state_t;

endpackage

// File: bcd_cnt.sv
`timescale 1ns/10ps

module bcd_cnt #(
    parameter int DIGITS = 1,  // Number of BCD digits
    parameter bit WRAP   = 1   // 1: roll over to zero, 0: stop at all nines
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clr,  // Synchronous clear, wins over up
    input  logic                up,   // Count enable, one step per clock
    output logic [4*DIGITS-1:0] cnt
);

    logic [4*DIGITS-1:0] nxt;       // Value after one BCD increment
    logic                carry;     // Ripple carry into the current digit
    logic                all_nine;  // Counter at its top value

    // **************************************************
    // BCD increment with digit carry
    // **************************************************
    always_comb begin
        nxt      = cnt;
        carry    = 1'b1;  // Add one at the lowest digit
        all_nine = 1'b1;
        for (int i = 0; i < DIGITS; i++) begin
            if (cnt[4*i +: 4] != 4'd9) all_nine = 1'b0;
            if (carry) begin
                if (cnt[4*i +: 4] == 4'd9) begin
                    nxt[4*i +: 4] = 4'd0;  // Digit wraps, carry moves on
                end else begin
                    nxt[4*i +: 4] = cnt[4*i +: 4] + 4'd1;
                    carry         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else if (up && (WRAP || !all_nine)) begin
            cnt <= nxt;  // Saturates at all nines when WRAP is 0
        end
    end

    for (genvar g = 0; g < DIGITS; g++) begin : g_digit_chk
        a_digit_bcd: assert property (@(posedge clk) disable iff (rst) cnt[4*g +: 4] <= 4'd9);
    end

endmodule

// File: sdram_stats.sv
`timescale 1ns/10ps

`include "sys_info_consts.svh"

module sdram_stats import sys_info_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  bank_rdy_t    rdy,      // Ready pulse per bank
    input  logic         lvbl,     // Vertical blank, low during blanking
    input  status_addr_t st_addr,
    output status_byte_t st_dout   // Total of the selected bank
);

    localparam int SEL_W = $clog2(`SYS_INFO_BANKS);  // Bank select bits

    logic         lvbl_l;                       // Delayed lvbl
    logic         lv_rise;                      // Start of the active frame
    status_byte_t run_cnt [`SYS_INFO_BANKS];    // Counts of the current frame
    status_byte_t total   [`SYS_INFO_BANKS];    // Counts of the previous frame

    assign lv_rise = lvbl & ~lvbl_l;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
        end
    end

    // **************************************************
    // Per-bank saturating counters
    // **************************************************
    for (genvar b = 0; b < `SYS_INFO_BANKS; b++) begin : g_bank
        always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
                run_cnt[b] <= '0;
                total[b]   <= '0;
            end else if (lv_rise) begin
                total[b]   <= run_cnt[b];          // Frame done, keep its total
                run_cnt[b] <= {7'd0, rdy[b]};      // Edge clock is already active
            end else if (lvbl && rdy[b] && run_cnt[b] != 8'hff) begin
                run_cnt[b] <= run_cnt[b] + 8'd1;   // Stops at 255
            end
        end

        // Only the frame start may bring a running count down
        a_run_mono: assert property (
            @(posedge clk) disable iff (rst)
            !lv_rise |=> run_cnt[b] >= $past(run_cnt[b])
        );
    end

    // Readout is combinational, sys_info registers it
    assign st_dout = total[st_addr[SEL_W-1:0]];

endmodule

// File: sys_info.sv
`timescale 1ns/10ps

`include "sys_info_consts.svh"

module sys_info import sys_info_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         sample,     // Audio sample strobe
    input  logic         frame_run,  // Frame counting enable
    input  logic         flip,       // Screen flip setting
    input  logic         lvbl,       // Vertical blank, active low
    input  logic [6:0]   core_mod,
    input  logic [1:0]   dial_x,
    input  bank_rdy_t    bank_rdy,
    input  status_addr_t st_addr,
    output status_byte_t st_dout     // Registered status byte
);

    localparam int WIN_W = $clog2(`SYS_INFO_WINDOW);  // Window counter width

    logic             lvbl_l;     // Delayed lvbl for edge detect
    logic             sample_l;   // Delayed sample strobe
    logic             frame_up;
    logic             sample_up;
    logic [WIN_W-1:0] win_cnt;    // Clock position inside the window
    logic             win_end;    // Last clock of the window
    bcd16_t           frame_cnt;
    status_byte_t     scnt;       // Samples seen in this window, BCD
    status_byte_t     rate;       // Count of the last full window
    status_byte_t     stats;      // Selected bank total

    assign frame_up  = lvbl & ~lvbl_l & frame_run;  // New frame while running
    assign sample_up = sample & ~sample_l;
    assign win_end   = win_cnt == WIN_W'(`SYS_INFO_WINDOW - 1);

    // **************************************************
    // Edge detect and measurement window
    // **************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b0;
            sample_l <= 1'b0;
            win_cnt  <= '0;
            rate     <= '0;
        end else begin
            lvbl_l   <= lvbl;
            sample_l <= sample;
            if (win_end) begin
                win_cnt <= '0;
                rate    <= scnt;  // Sample counter clears on this same clock
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    bcd_cnt #(
        .DIGITS (`SYS_INFO_FRAME_DIGITS),
        .WRAP   (1'b1)
    ) u_frame_cnt (
        .clk    (clk),
        .rst    (rst),
        .clr    (1'b0),       // Runs from reset onwards
        .up     (frame_up),
        .cnt    (frame_cnt)
    );

    // Saturates at 99 within one window
    bcd_cnt #(
        .DIGITS (`SYS_INFO_RATE_DIGITS),
        .WRAP   (1'b0)
    ) u_sample_cnt (
        .clk    (clk),
        .rst    (rst),
        .clr    (win_end),
        .up     (sample_up),
        .cnt    (scnt)
    );

    sdram_stats u_stats (
        .clk     (clk),
        .rst     (rst),
        .rdy     (bank_rdy),
        .lvbl    (lvbl),
        .st_addr (st_addr),
        .st_dout (stats)
    );

    // **************************************************
    // Status register map
    // **************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            case (st_addr[`SYS_INFO_RGN_MSB:`SYS_INFO_RGN_LSB])
                `SYS_INFO_REG_STATS: st_dout <= stats;
                `SYS_INFO_REG_FRAME: st_dout <= st_addr[0] ? frame_cnt[15:8] : frame_cnt[7:0];
                `SYS_INFO_REG_RATE:  st_dout <= rate;
                `SYS_INFO_REG_CFG:   st_dout <= {core_mod[3:0], dial_x, 1'b0, flip};
            endcase
        end
    end

endmodule

// File: status_port.sv
`timescale 1ns/10ps

module status_port import sys_info_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         req_valid,
    output logic         req_ready,
    input  status_addr_t req_addr,
    output logic         resp_valid,
    input  logic         resp_ready,
    output status_byte_t resp_data,
    output status_addr_t st_addr,   // To sys_info
    input  status_byte_t st_dout    // Registered one clock after st_addr
);

    port_state_t state;

    assign req_ready = state == IDLE;  // One read in flight

    // **************************************************
    // Read FSM
    // **************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            st_addr    <= '0;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (req_valid) begin
                    st_addr <= req_addr;  // Address goes out on the bus
                    state   <= WAIT_DATA;
                end
                WAIT_DATA: state <= RESP;  // st_dout registers this clock
                RESP: if (!resp_valid) begin
                    resp_valid <= 1'b1;    // Byte captured below
                end else if (resp_ready) begin
                    resp_valid <= 1'b0;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RESP && !resp_valid) resp_data <= st_dout;
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));
    // Goes high on the second edge after the handshake, seen high on the third
    a_resp_lat: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |-> ##3 $rose(resp_valid));

endmodule

// File: sys_info_top.sv
`timescale 1ns/10ps

module sys_info_top import sys_info_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         sample,
    input  logic         frame_run,
    input  logic         flip,
    input  logic         lvbl,
    input  logic [6:0]   core_mod,
    input  logic [1:0]   dial_x,
    input  bank_rdy_t    bank_rdy,
    input  logic         req_valid,
    output logic         req_ready,
    input  status_addr_t req_addr,
    output logic         resp_valid,
    input  logic         resp_ready,
    output status_byte_t resp_data
);

    status_addr_t st_addr;  // Status bus address, from the port
    status_byte_t st_dout;  // Status bus data, from the collector

    // Host side
    status_port u_port (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .st_addr    (st_addr),
        .st_dout    (st_dout)
    );

    sys_info u_info (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .frame_run (frame_run),
        .flip      (flip),
        .lvbl      (lvbl),
        .core_mod  (core_mod),
        .dial_x    (dial_x),
        .bank_rdy  (bank_rdy),
        .st_addr   (st_addr),
        .st_dout   (st_dout)
    );

endmodule

// File: tb_sys_info.sv
`timescale 1ns/10ps

`include "sys_info_consts.svh"

module tb_sys_info import sys_info_pkg::*; ();

    localparam int RST_CYCLES = 10;
    localparam int BLANK      = 60;                 // Clocks with lvbl low
    localparam int ACTIVE     = 300;                // Clocks with lvbl high
    localparam int FRAME_LEN  = BLANK + ACTIVE;
    localparam int WINDOW     = `SYS_INFO_WINDOW;
    localparam int PULSE_AT   = 100;                // First sample pulse in a window
    localparam int REQ_LIMIT  = 20;
    localparam int RESP_LIMIT = 50;

    logic         clk, rst, sample, frame_run, flip, lvbl;
    logic [6:0]   core_mod;
    logic [1:0]   dial_x;
    bank_rdy_t    bank_rdy;
    logic         req_valid, req_ready, resp_valid, resp_ready;
    status_addr_t req_addr;
    status_byte_t resp_data;

    int seed = 1;
    int checks = 0;
    int errors = 0;
    int e0;                                         // Error count at test start
    // Reference model state, kept by the stimulus processes
    int exp_frames = 0;                             // Frames counted, binary
    int exp_rate = 0;                               // Last full window, saturated
    int exp_total [`SYS_INFO_BANKS] = '{default: 0};
    int cur_cnt [`SYS_INFO_BANKS] = '{default: 0};  // Running frame counts
    int frames_seen = 0;                            // lvbl rises driven
    int win_count = 0;                              // Windows completed
    int spw = 0;                                    // Sample pulses per window
    int k_cur = 0;                                  // Pulses in the current window
    int wpos;                                       // Window offset of next edge
    logic run_req = 1'b0;
    logic fr_cur;
    logic frame_mid = 1'b0;
    logic win_mid = 1'b0;
    bank_rdy_t rdy_now;
    status_addr_t addr;
    status_byte_t rd;

    sys_info_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    // **************************************************
    // Reference model and checking
    // **************************************************
    function automatic bcd16_t bin_to_bcd(input int v);
        bcd16_t r;
        int     x;
        x = v;
        for (int i = 0; i < 4; i++) begin
            r[4*i +: 4] = 4'(x % 10);
            x = x / 10;
        end
        return r;
    endfunction

    function automatic status_byte_t ref_byte(input status_addr_t a);
        bcd16_t fbcd;
        bcd16_t rbcd;
        fbcd = bin_to_bcd(exp_frames);
        rbcd = bin_to_bcd(exp_rate);
        case (a[`SYS_INFO_RGN_MSB:`SYS_INFO_RGN_LSB])
            `SYS_INFO_REG_STATS: return 8'(exp_total[a[1:0]]);
            `SYS_INFO_REG_FRAME: return a[0] ? fbcd[15:8] : fbcd[7:0];
            `SYS_INFO_REG_RATE:  return rbcd[7:0];
            default:             return {core_mod[3:0], dial_x, 1'b0, flip};
        endcase
    endfunction

    function automatic bank_rdy_t rnd_rdy();
        logic [31:0] r;
        r = $random(seed);
        return {|r[8:5], r[3] | r[4], r[1] & r[2], r[0]};  // Bank 3 busy enough to saturate
    endfunction

    task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("ERROR: %s expected 0x%0h, got 0x%0h", name, expv, actv);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        $display("[%s] finished with %0d errors", name, errors - e0);
    endtask

    // **************************************************
    // Host read with response stalls
    // **************************************************
    task automatic read_byte(input status_addr_t a, output status_byte_t data);
        int   n;
        logic seen;
        logic done;
        req_valid  <= 1'b1;
        req_addr   <= a;
        resp_ready <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > REQ_LIMIT) abort_run("request was never accepted");
        end while (!req_ready);                     // Handshake on this edge
        req_valid <= 1'b0;
        n    = 0;
        seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            n++;
            if (n > RESP_LIMIT) abort_run("no response arrived");
            check("req_ready", 0, req_ready);       // Busy until accepted
            if (resp_valid && !seen) begin
                seen = 1'b1;
                data = resp_data;
                check("resp_valid delay", 2, n - 1);  // Seen one edge after it rose
            end
            if (seen) check("resp_data hold", data, resp_data);
            if (resp_valid && resp_ready) done = 1'b1;
            resp_ready <= ($random(seed) & 3) != 0;  // Stall about one clock in four
        end
        resp_ready <= 1'b0;
    endtask

    task automatic read_check(input status_addr_t a);
        status_byte_t expv;
        status_byte_t got;
        expv = ref_byte(a);
        read_byte(a, got);
        check($sformatf("resp_data at 0x%02h", a), expv, got);
    endtask

    task automatic wait_frames(input int n);
        int start;
        int t;
        start = frames_seen;
        t = 0;
        while (frames_seen < start + n) begin
            @(posedge clk);
            t++;
            if (t > n * FRAME_LEN + 100) abort_run("lvbl frames stopped");
        end
    endtask

    task automatic wait_windows(input int n);
        int start;
        int t;
        start = win_count;
        t = 0;
        while (win_count < start + n) begin
            @(posedge clk);
            t++;
            if (t > n * WINDOW + 100) abort_run("sample windows stopped");
        end
    endtask

    // Waits for a point far from frame and window boundaries
    task automatic wait_quiet(input logic need_frame, input logic need_win);
        int t;
        t = 0;
        while ((need_frame && !frame_mid) || (need_win && !win_mid)) begin
            @(posedge clk);
            t++;
            if (t > 4 * WINDOW) abort_run("no quiet point for a read");
        end
    endtask

    // **************************************************
    // Stimulus processes
    // **************************************************
    initial begin : frame_gen
        lvbl      = 1'b0;
        frame_run = 1'b0;
        bank_rdy  = '0;
        repeat (RST_CYCLES + 1) @(posedge clk);
        forever begin
            frame_run <= run_req;                   // Settles during blanking
            fr_cur    = run_req;
            frame_mid = 1'b0;
            for (int i = 0; i < BLANK; i++) begin
                lvbl     <= 1'b0;
                bank_rdy <= rnd_rdy();              // Ignored while blanking
                @(posedge clk);
            end
            for (int i = 0; i < ACTIVE; i++) begin
                rdy_now = rnd_rdy();
                lvbl     <= 1'b1;
                bank_rdy <= rdy_now;
                if (i == 0) begin                   // Rising lvbl edge
                    if (fr_cur) exp_frames = (exp_frames + 1) % 10000;
                    for (int b = 0; b < `SYS_INFO_BANKS; b++) begin
                        exp_total[b] = cur_cnt[b];
                        cur_cnt[b]   = 0;
                    end
                    frames_seen++;
                end
                for (int b = 0; b < `SYS_INFO_BANKS; b++) begin
                    if (rdy_now[b] && cur_cnt[b] < 255) cur_cnt[b]++;
                end
                frame_mid = (i >= 40) && (i < ACTIVE - 40);
                @(posedge clk);
            end
        end
    end

    initial begin : sample_gen
        sample = 1'b0;
        repeat (RST_CYCLES + 1) @(posedge clk);
        wpos = 2;                                   // First edge after reset is offset 1
        forever begin
            if (wpos == 1) k_cur = spw;
            sample <= (wpos >= PULSE_AT) && (wpos < PULSE_AT + 2 * k_cur) && (wpos % 2 == 0);
            if (wpos == 0) begin                    // Rate loads on this edge
                exp_rate = (k_cur > 99) ? 99 : k_cur;
                win_count++;
            end
            win_mid = (wpos >= 100) && (wpos < 800);
            @(posedge clk);
            wpos = (wpos + 1) % WINDOW;
        end
    end

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin : main_seq
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        core_mod   = '0;
        dial_x     = '0;
        flip       = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        e0 = errors;
        check("req_ready", 1, req_ready);
        check("resp_valid", 0, resp_valid);
        for (int r = 0; r < 4; r++) begin
            for (int lo = 0; lo < 4; lo++) begin
                read_byte({2'(r), 6'(lo)}, rd);
                check($sformatf("resp_data at 0x%02h", {2'(r), 6'(lo)}), 0, rd);
            end
        end
        report_test("reset");

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            core_mod <= 7'($random(seed));
            dial_x   <= 2'($random(seed));
            flip     <= 1'($random(seed));
            repeat (3) @(posedge clk);              // Let the inputs settle
            read_check({2'b11, 6'($random(seed))});
        end
        report_test("config");

        e0 = errors;
        wait_quiet(1'b1, 1'b0);
        run_req = 1'b1;
        wait_frames(103);                           // Reaches the high byte
        run_req = 1'b0;
        wait_frames(3);                             // These must not count
        wait_quiet(1'b1, 1'b0);
        read_check(8'h40);
        read_check(8'h41);
        report_test("frame");

        e0 = errors;
        spw = 37;
        wait_windows(2);
        wait_quiet(1'b0, 1'b1);
        read_check(8'h80);
        spw = 120;                                  // Over the 99 limit
        wait_windows(2);
        wait_quiet(1'b0, 1'b1);
        read_check(8'h80);
        read_check(8'hbf);
        report_test("rate");

        e0 = errors;
        for (int f = 0; f < 2; f++) begin
            wait_frames(1);
            wait_quiet(1'b1, 1'b0);
            for (int b = 0; b < `SYS_INFO_BANKS; b++) begin
                read_check({2'b00, 4'($random(seed)), 2'(b)});
            end
        end
        report_test("stats");

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            addr = 8'($random(seed));
            wait_quiet(1'b1, 1'b1);
            read_check(addr);
        end
        report_test("handshake");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
sys_info_pkg.sv
bcd_cnt.sv
sdram_stats.sv
sys_info.sv
status_port.sv
sys_info_top.sv
tb_sys_info.sv

// File: Bender.yml
package:
  name: sys_info

export_include_dirs:
  - .

sources:
  - files:
      - sys_info_pkg.sv
      - bcd_cnt.sv
      - sdram_stats.sv
      - sys_info.sv
      - status_port.sv
      - sys_info_top.sv
  - target: test
    files:
      - tb_sys_info.sv
